// File: include/dac_defs.svh
`ifndef DAC_DEFS_SVH
`define DAC_DEFS_SVH

// ---------------------------------------------------------------------
// register offsets from the channel base, low nibble of reg_addr
// ---------------------------------------------------------------------
`define OFF_ADC_DATA   4'd0       // adc conversion result
`define OFF_DAC_CTRL   4'd1       // dac command word, the only one decoded here
`define OFF_POT_CTRL   4'd2       // pot control
`define OFF_POT_DATA   4'd3       // pot data
`define OFF_ENC_LOAD   4'd4       // encoder preload
`define OFF_ENC_DATA   4'd5       // encoder quadrature count
`define OFF_PER_DATA   4'd6       // encoder period
`define OFF_FREQ_DATA  4'd7       // encoder frequency
`define OFF_ACC_DATA   4'd8       // encoder acceleration

// ---------------------------------------------------------------------
// daisy chain and serial timing
// ---------------------------------------------------------------------
`define NUM_DACS       4          // converters in the chain, 1 to 15
`define SCLK_HALF      2          // sysclk cycles per sclk half period

// mid-scale code, used for nop words and after reset
`define DAC_VAL_INIT   16'h8000

`endif

// File: list.f
+incdir+include
source/dac_pkg.sv
source/dac_ctrl.sv
source/dac_spi_chain.sv
source/dac_subsystem.sv
verification/dac_assertions.sv
verification/dac_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dac testbench with verilator, run from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module dac_tb -f list.f -o dac_sim

status=0
./obj_dir/dac_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "dac simulation run reported a failure"
    exit 1
fi
echo "dac simulation run finished without failure"

// File: source/dac_ctrl.sv
`default_nettype none

`include "dac_defs.svh"

module dac_ctrl (
    input  wire         sysclk,       // system clock
    input  wire         reset,        // sync reset, active low
    input  wire         reg_wen,      // single word write strobe
    input  wire         blk_wen,      // end of block write strobe
    input  wire  [7:0]  reg_addr,     // channel in [7:4], offset in [3:0]
    input  wire  [31:0] reg_wdata,    // value in [15:0]
    input  wire  [3:0]  addr_dac,     // word index from serializer
    input  wire         busy,         // serializer running
    input  wire         flush,        // nop the word at addr_dac
    output logic [31:0] reg_rdata,    // readback of selected channel
    output logic        trig,         // start serializer
    output logic [31:0] dac_word      // word at addr_dac
);

    // ---------------------------------------------------------------------
    // command words
    // ---------------------------------------------------------------------
    localparam logic [31:0] NOP_WORD = {8'h00, dac_pkg::CMD_NOP, 4'h0, `DAC_VAL_INIT};

    logic [3:0]  reg_chan;            // 0-based dac index
    logic        off_hit;             // dac control offset selected
    logic        wr_en;               // accepted register write
    logic [31:0] wru_word;            // write/update word from reg_wdata

    logic [31:0] cmd_mem  [`NUM_DACS];  // words for the next transfer
    logic [31:0] copy_mem [`NUM_DACS];  // last written, never flushed

    assign reg_chan = reg_addr[7:4] - 4'd1;   // channel 1 is dac 0, 0 wraps out of range
    assign off_hit  = (reg_addr[3:0] == `OFF_DAC_CTRL);
    assign wr_en    = reg_wen && off_hit && !busy;  // locked out during transfer
    assign wru_word = {8'h00, dac_pkg::CMD_WRU, 4'h0, reg_wdata[15:0]};

    // ---------------------------------------------------------------------
    // command memory
    // ---------------------------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        for (int i = 0; i < `NUM_DACS; i++)
        begin
            if (!reset)
                cmd_mem[i] <= NOP_WORD;
            else if (flush && addr_dac == 4'(i))
                cmd_mem[i] <= NOP_WORD;       // sent once, then back to nop
            else if (wr_en && reg_chan == 4'(i))
                cmd_mem[i] <= wru_word;
        end
    end

    // ---------------------------------------------------------------------
    // readback copy
    // ---------------------------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        for (int i = 0; i < `NUM_DACS; i++)
        begin
            if (!reset)
                copy_mem[i] <= NOP_WORD;
            else if (wr_en && reg_chan == 4'(i))
                copy_mem[i] <= wru_word;      // flush does not touch this one
        end
    end

    // read ports, plain muxes over the channels
    always_comb
    begin
        dac_word  = NOP_WORD;
        reg_rdata = 32'h0;                    // unmapped channel reads zero
        for (int i = 0; i < `NUM_DACS; i++)
        begin
            if (addr_dac == 4'(i))
                dac_word = cmd_mem[i];
            if (reg_chan == 4'(i))
                reg_rdata = copy_mem[i];
        end
    end

    // ---------------------------------------------------------------------
    // trigger
    // ---------------------------------------------------------------------
    // blk_wen comes with the last reg_wen of a block; one cycle later that
    // word is already in cmd_mem
    always_ff @(posedge sysclk)
    begin
        if (!reset)
            trig <= 1'b0;
        else
            trig <= blk_wen && off_hit;
    end

endmodule

`default_nettype wire

// File: source/dac_pkg.sv
`default_nettype none

package dac_pkg;

    // ---------------------------------------------------------------------
    // command nibble of an LTC2601 word
    // ---------------------------------------------------------------------
    typedef enum logic [3:0] {
        CMD_WRU = 4'h3,           // write input reg and update output
        CMD_NOP = 4'hF            // no operation, dac output unchanged
    } dac_cmd_t;

    // word layout: 8 zero bits, opcode, 4 zero address bits, 16-bit value

    // ---------------------------------------------------------------------
    // serializer states
    // ---------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE  = 2'd0,             // waiting for trig, csel high
        LOAD  = 2'd1,             // capture word, flush it to nop
        SHIFT = 2'd2,             // clocking 32 bits out
        DONE  = 2'd3              // one cycle tail before csel rises
    } spi_state_t;

endpackage

`default_nettype wire

// File: source/dac_spi_chain.sv
`default_nettype none

`include "dac_defs.svh"

module dac_spi_chain (
    input  wire         sysclk,       // system clock
    input  wire         reset,        // sync reset, active low
    input  wire         trig,         // one-cycle start pulse
    input  wire  [31:0] dac_word,     // command word at addr_dac
    output logic [3:0]  addr_dac,     // index of word being loaded
    output logic        busy,         // transfer in progress
    output logic        flush,        // word at addr_dac back to nop
    output logic        sclk,         // serial clock, idles low
    output logic        mosi,         // serial data, msb first
    output logic        csel          // chip select, active low
);

    // ---------------------------------------------------------------------
    // constants
    // ---------------------------------------------------------------------
    localparam int DIV_W = ($clog2(`SCLK_HALF) > 0) ? $clog2(`SCLK_HALF) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST  = DIV_W'(`SCLK_HALF - 1);  // end of half period
    localparam logic [3:0]       LAST_WORD = 4'(`NUM_DACS - 1);      // far end of chain first
    localparam logic [4:0]       LAST_BIT  = 5'd31;

    dac_pkg::spi_state_t state;       // fsm state

    logic [DIV_W-1:0] div_cnt;        // sclk half period counter
    logic [4:0]       bit_cnt;        // bits sent of current word
    logic [31:0]      shift_reg;      // outgoing word, msb at top
    logic             active;         // divider running
    logic             half_done;      // divider terminal count
    logic             fall_edge;      // sclk about to drop

    assign active    = (state == dac_pkg::LOAD) || (state == dac_pkg::SHIFT);
    assign half_done = (div_cnt == DIV_LAST);
    assign fall_edge = (state == dac_pkg::SHIFT) && half_done && sclk;

    // ---------------------------------------------------------------------
    // serial clock divider
    // ---------------------------------------------------------------------
    // load counts as the first low cycle of bit 31, so a word takes
    // exactly 32 sclk periods
    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            div_cnt <= '0;
            sclk    <= 1'b0;
        end
        else if (!active)
        begin
            div_cnt <= '0;            // idle and done hold the divider
            sclk    <= 1'b0;
        end
        else if (half_done)
        begin
            div_cnt <= '0;
            sclk    <= ~sclk;         // rise from low phase, fall from high
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ---------------------------------------------------------------------
    // transfer fsm
    // ---------------------------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            state    <= dac_pkg::IDLE;
            bit_cnt  <= '0;
            addr_dac <= '0;
        end
        else
        begin
            case (state)
                dac_pkg::IDLE:
                begin
                    if (trig)         // trig while busy never reaches here
                    begin
                        addr_dac <= LAST_WORD;
                        state    <= dac_pkg::LOAD;
                    end
                end
                dac_pkg::LOAD:
                begin
                    bit_cnt <= '0;
                    state   <= dac_pkg::SHIFT;
                end
                dac_pkg::SHIFT:
                begin
                    if (fall_edge)
                    begin
                        if (bit_cnt != LAST_BIT)
                            bit_cnt <= bit_cnt + 5'd1;
                        else if (addr_dac == 4'd0)
                            state <= dac_pkg::DONE;      // dac 0 was the last
                        else
                        begin
                            addr_dac <= addr_dac - 4'd1; // next word down
                            state    <= dac_pkg::LOAD;
                        end
                    end
                end
                dac_pkg::DONE:
                begin
                    state <= dac_pkg::IDLE;              // csel rises here
                end
                default:
                begin
                    state <= dac_pkg::IDLE;
                end
            endcase
        end
    end

    // ---------------------------------------------------------------------
    // shift register
    // ---------------------------------------------------------------------
    always_ff @(posedge sysclk)
    begin
        if (state == dac_pkg::LOAD)
            shift_reg <= dac_word;                       // same edge as nop flush
        else if (fall_edge)
            shift_reg <= {shift_reg[30:0], 1'b0};        // next bit on sclk fall
    end

    // in load the word is not captured yet, so take bit 31 straight from memory
    always_comb
    begin
        case (state)
            dac_pkg::LOAD:  mosi = dac_word[31];
            dac_pkg::SHIFT: mosi = shift_reg[31];
            default:        mosi = 1'b0;                 // quiet between transfers
        endcase
    end

    assign busy  = (state != dac_pkg::IDLE);
    assign csel  = ~busy;                                // frames the whole chain
    assign flush = (state == dac_pkg::LOAD);             // one cycle per word

endmodule

`default_nettype wire

// File: source/dac_subsystem.sv
`default_nettype none

module dac_subsystem (
    input  wire         sysclk,       // system clock
    input  wire         reset,        // sync reset, active low
    input  wire         reg_wen,      // register write strobe
    input  wire         blk_wen,      // block write strobe
    input  wire  [7:0]  reg_addr,     // channel and offset
    input  wire  [31:0] reg_wdata,    // write data
    output logic [31:0] reg_rdata,    // readback data
    output logic        sclk,         // spi clock
    output logic        mosi,         // spi data
    output logic        csel          // spi chip select, active low
);

    // ---------------------------------------------------------------------
    // regfile to serializer
    // ---------------------------------------------------------------------
    logic        trig;                // start pulse
    logic [31:0] dac_word;            // word at addr_dac
    logic [3:0]  addr_dac;            // serializer word index
    logic        busy;                // write lockout
    logic        flush;               // nop after load

    dac_ctrl dac_ctrl_inst (
        .sysclk    (sysclk),
        .reset     (reset),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .addr_dac  (addr_dac),
        .busy      (busy),
        .flush     (flush),
        .reg_rdata (reg_rdata),
        .trig      (trig),
        .dac_word  (dac_word)
    );

    dac_spi_chain dac_spi_chain_inst (
        .sysclk    (sysclk),
        .reset     (reset),
        .trig      (trig),
        .dac_word  (dac_word),
        .addr_dac  (addr_dac),
        .busy      (busy),
        .flush     (flush),
        .sclk      (sclk),
        .mosi      (mosi),
        .csel      (csel)
    );

endmodule

`default_nettype wire

// File: verification/dac_assertions.sv
`default_nettype none

module dac_assertions (
    input wire        sysclk,         // system clock
    input wire        reset,          // sync reset, active low
    input wire [1:0]  state,          // serializer fsm state
    input wire        trig,           // start pulse from the regfile
    input wire [3:0]  addr_dac,       // word index
    input wire [4:0]  bit_cnt,        // bits sent of current word
    input wire        flush,          // nop flush pulse
    input wire [31:0] dac_word,       // word at addr_dac
    input wire [31:0] shift_reg,      // outgoing word
    input wire        sclk,           // serial clock
    input wire        mosi,           // serial data
    input wire        csel            // chip select, active low
);

    timeunit 1ns;
    timeprecision 1ps;

    // ---------------------------------------------------------------------
    // framing
    // ---------------------------------------------------------------------
    // csel drops only in the cycle after a trigger
    csel_starts_on_trig: assert property (@(posedge sysclk) disable iff (!reset)
        $fell(csel) |-> $past(trig))
        else $error("csel fell without a trigger");

    // csel rises only once the last bit of dac 0 is out
    csel_ends_on_last_bit: assert property (@(posedge sysclk) disable iff (!reset)
        $rose(csel) |-> ($past(state) == dac_pkg::DONE && $past(addr_dac) == 4'd0
                         && $past(bit_cnt) == 5'd31))
        else $error("csel rose before the whole chain was sent");

    sclk_low_idle: assert property (@(posedge sysclk) disable iff (!reset)
        csel |-> !sclk)
        else $error("sclk high while csel is high");

    // data only moves while sclk is low
    mosi_hold_high: assert property (@(posedge sysclk) disable iff (!reset)
        (sclk && $past(sclk)) |-> $stable(mosi))
        else $error("mosi changed during sclk high phase");

    // ---------------------------------------------------------------------
    // flush
    // ---------------------------------------------------------------------
    // the word flushed to nop is the word taken into the shift register
    flush_in_load: assert property (@(posedge sysclk) disable iff (!reset)
        flush |=> (shift_reg == $past(dac_word)))
        else $error("flush without the word being loaded");

endmodule

bind dac_spi_chain dac_assertions dac_assertions_inst (
    .sysclk    (sysclk),
    .reset     (reset),
    .state     (state),
    .trig      (trig),
    .addr_dac  (addr_dac),
    .bit_cnt   (bit_cnt),
    .flush     (flush),
    .dac_word  (dac_word),
    .shift_reg (shift_reg),
    .sclk      (sclk),
    .mosi      (mosi),
    .csel      (csel)
);

`default_nettype wire

// File: verification/dac_tb.sv
`default_nettype none

`include "dac_defs.svh"

module dac_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // ---------------------------------------------------------------------
    // table operations and constants
    // ---------------------------------------------------------------------
    localparam int OP_IDLE = 0;       // csel high, sclk low for a while
    localparam int OP_RD   = 1;       // readback of one channel
    localparam int OP_WR   = 2;       // single register write
    localparam int OP_BLK  = 3;       // write plus blk_wen, then transfer
    localparam int OP_TRIG = 4;       // blk_wen alone, then transfer
    localparam int OP_LOCK = 5;       // blk_wen alone, write while busy
    localparam int OP_XFER = 6;       // decoded word of one dac
    localparam int OP_OFF  = 7;       // write plus blk_wen at a foreign offset
    localparam int TAB_MAX = 64;

    localparam int XFER_BITS   = 32 * `NUM_DACS;
    localparam int XFER_CYCLES = XFER_BITS * 2 * `SCLK_HALF;
    localparam logic [31:0] NOP_WORD = {8'h00, dac_pkg::CMD_NOP, 4'h0, `DAC_VAL_INIT};

    logic        sysclk;
    logic        reset;
    logic        reg_wen;
    logic        blk_wen;
    logic [7:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic        sclk;
    logic        mosi;
    logic        csel;

    int          tab_op    [TAB_MAX];
    int          tab_dac   [TAB_MAX];
    logic [15:0] tab_value [TAB_MAX];
    logic [31:0] tab_exp   [TAB_MAX];
    int          tab_len = 0;

    logic [31:0] model_cmd  [`NUM_DACS];   // words the next transfer should carry
    logic [31:0] model_copy [`NUM_DACS];   // expected readback

    int checks   = 0;
    int errors   = 0;
    int timeouts = 0;

    dac_subsystem dac_subsystem_inst (
        .sysclk    (sysclk),
        .reset     (reset),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .sclk      (sclk),
        .mosi      (mosi),
        .csel      (csel)
    );

    initial
    begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;  // 4 ns period
    end

    // ---------------------------------------------------------------------
    // serial decoder, sampled mid-cycle
    // ---------------------------------------------------------------------
    logic [XFER_BITS-1:0] dec_stream = '0;   // first word out ends on top
    int   dec_count  = 0;
    int   low_cycles = 0;                    // cycles with csel low
    logic sclk_prev  = 1'b0;
    logic csel_prev  = 1'b1;

    always @(negedge sysclk)
    begin
        if (!csel)
        begin
            if (csel_prev)
            begin
                dec_stream = '0;            // new frame
                dec_count  = 0;
                low_cycles = 0;
            end
            low_cycles++;
            if (sclk && !sclk_prev)
            begin
                dec_stream = {dec_stream[XFER_BITS-2:0], mosi};
                dec_count++;
            end
        end
        sclk_prev = sclk;
        csel_prev = csel;
    end

    // ---------------------------------------------------------------------
    // expected words and table building
    // ---------------------------------------------------------------------
    function automatic logic [31:0] expected_wru(input logic [15:0] value);
        return {8'h00, dac_pkg::CMD_WRU, 4'h0, value};
    endfunction

    task automatic add_row(input int op, input int dac, input logic [15:0] value,
                           input logic [31:0] expected);
        tab_op[tab_len]    = op;
        tab_dac[tab_len]   = dac;
        tab_value[tab_len] = value;
        tab_exp[tab_len]   = expected;
        tab_len++;
    endtask

    task automatic model_write(input int dac, input logic [15:0] value);
        model_cmd[dac]  = expected_wru(value);
        model_copy[dac] = expected_wru(value);
    endtask

    // one check per dac in chain order, then the model flushes to nop
    task automatic add_xfer_rows();
        for (int d = `NUM_DACS - 1; d >= 0; d--)
        begin
            add_row(OP_XFER, d, 16'h0, model_cmd[d]);
            model_cmd[d] = NOP_WORD;
        end
    endtask

    task automatic add_rd_rows();
        for (int d = 0; d < `NUM_DACS; d++)
            add_row(OP_RD, d, 16'h0, model_copy[d]);
    endtask

    task automatic build_table();
        logic [15:0] v;
        int          last;
        int          lock_dac;
        last     = `NUM_DACS - 1;
        lock_dac = (`NUM_DACS > 1) ? 1 : 0;
        for (int d = 0; d < `NUM_DACS; d++)
        begin
            model_cmd[d]  = NOP_WORD;
            model_copy[d] = NOP_WORD;
        end
        add_row(OP_IDLE, 0, 16'h0, 32'h0);          // reset state
        add_rd_rows();
        for (int d = 0; d < last; d += 2)           // even dacs only
        begin
            v = 16'($urandom);
            model_write(d, v);
            add_row(OP_WR, d, v, 32'h0);
            add_row(OP_RD, d, 16'h0, model_copy[d]);
        end
        v = 16'($urandom);
        model_write(last, v);
        add_row(OP_BLK, last, v, 32'h0);            // block closes on far dac
        add_xfer_rows();
        add_row(OP_TRIG, last, 16'h0, 32'h0);       // nothing new, all nop
        add_xfer_rows();
        add_rd_rows();                              // readback survives flush
        v = 16'($urandom);
        model_write(lock_dac, v);
        add_row(OP_WR, lock_dac, v, 32'h0);
        add_row(OP_LOCK, lock_dac, ~v, 32'h0);      // dropped write
        add_xfer_rows();
        add_row(OP_RD, lock_dac, 16'h0, model_copy[lock_dac]);
        add_row(OP_OFF, 0, 16'($urandom), 32'h0);
        add_row(OP_OFF, last, 16'($urandom), 32'h0);
        add_rd_rows();
        add_row(OP_TRIG, 0, 16'h0, 32'h0);          // foreign writes left no trace
        add_xfer_rows();
    endtask

    // ---------------------------------------------------------------------
    // bus driving and waiting
    // ---------------------------------------------------------------------
    task automatic drive(input int dac, input logic [3:0] off, input logic [15:0] value,
                         input logic wen, input logic blk);
        @(posedge sysclk);
        reg_wen   <= wen;
        blk_wen   <= blk;
        reg_addr  <= {4'(dac + 1), off};         // channel 1 is dac 0
        reg_wdata <= {16'($urandom), value};     // upper half ignored
        @(posedge sysclk);
        reg_wen   <= 1'b0;
        blk_wen   <= 1'b0;
    endtask

    task automatic wait_csel(input logic level, input int limit, output bit ok);
        int n;
        n = 0;
        while (csel !== level && n < limit)
        begin
            @(negedge sysclk);
            n++;
        end
        ok = (csel === level);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic run_transfer(input bit write_mid, input int dac, input logic [15:0] value);
        bit ok;
        wait_csel(1'b0, 8, ok);
        if (!ok)
        begin
            timeouts++;
            $display("Timeout at %0d ns: csel did not fall after the trigger", $time);
            return;
        end
        if (write_mid)
            drive(dac, `OFF_DAC_CTRL, value, 1'b1, 1'b0);   // busy, must be ignored
        wait_csel(1'b1, XFER_CYCLES + 16, ok);
        if (!ok)
        begin
            timeouts++;
            $display("Timeout at %0d ns: transfer did not end, csel stayed low", $time);
            return;
        end
        checks += 2;
        if (dec_count != XFER_BITS)
            report_mismatch("sclk rising edges", 32'(XFER_BITS), 32'(dec_count));
        if (low_cycles < XFER_CYCLES || low_cycles > XFER_CYCLES + 2)
            report_mismatch("csel low cycles", 32'(XFER_CYCLES), 32'(low_cycles));
    endtask

    task automatic watch_idle(input int cycles);
        for (int n = 0; n < cycles; n++)
        begin
            @(negedge sysclk);
            checks++;
            if (csel !== 1'b1 || sclk !== 1'b0)
            begin
                errors++;
                $display("Error at %0d ns: csel,sclk expected 1,0, got %b,%b",
                         $time, csel, sclk);
            end
        end
    endtask

    // ---------------------------------------------------------------------
    // table loop
    // ---------------------------------------------------------------------
    task automatic apply_row(input int i);
        case (tab_op[i])
            OP_IDLE: watch_idle(8);
            OP_RD:
            begin
                drive(tab_dac[i], `OFF_DAC_CTRL, 16'h0, 1'b0, 1'b0);
                @(negedge sysclk);
                checks++;
                if (reg_rdata !== tab_exp[i])
                    report_mismatch($sformatf("reg_rdata of dac %0d", tab_dac[i]),
                                    tab_exp[i], reg_rdata);
            end
            OP_WR: drive(tab_dac[i], `OFF_DAC_CTRL, tab_value[i], 1'b1, 1'b0);
            OP_BLK:
            begin
                drive(tab_dac[i], `OFF_DAC_CTRL, tab_value[i], 1'b1, 1'b1);
                run_transfer(1'b0, 0, 16'h0);
            end
            OP_TRIG:
            begin
                drive(tab_dac[i], `OFF_DAC_CTRL, 16'h0, 1'b0, 1'b1);
                run_transfer(1'b0, 0, 16'h0);
            end
            OP_LOCK:
            begin
                drive(tab_dac[i], `OFF_DAC_CTRL, 16'h0, 1'b0, 1'b1);
                run_transfer(1'b1, tab_dac[i], tab_value[i]);
            end
            OP_XFER:
            begin
                checks++;
                if (dec_stream[tab_dac[i]*32 +: 32] !== tab_exp[i])
                    report_mismatch($sformatf("mosi word of dac %0d", tab_dac[i]),
                                    tab_exp[i], dec_stream[tab_dac[i]*32 +: 32]);
            end
            OP_OFF:
            begin
                drive(tab_dac[i], `OFF_POT_CTRL, tab_value[i], 1'b1, 1'b1);
                watch_idle(12);                      // no transfer may start
            end
            default:
            begin
                errors++;
                $display("Table row %0d holds an unknown operation", i);
            end
        endcase
    endtask

    initial
    begin
        reset     <= 1'b0;
        reg_wen   <= 1'b0;
        blk_wen   <= 1'b0;
        reg_addr  <= 8'h00;
        reg_wdata <= 32'h0;
        void'($urandom(77628));
        build_table();
        repeat (5) @(posedge sysclk);
        reset <= 1'b1;
        for (int i = 0; i < tab_len; i++)
            apply_row(i);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
